//--- logic/qeciphy_tx_consts.svh
/* Fixed frame constants of the transmit framer
   Frame and group lengths, FAW pattern, control tags, CRC-16 polynomial and seed */
`ifndef QECIPHY_TX_CONSTS_SVH
`define QECIPHY_TX_CONSTS_SVH

// Frame schedule
`define QECIPHY_FRAME_SLOTS 64
`define QECIPHY_GROUP_DATA 6

// Alignment word content
`define QECIPHY_FAW_PATTERN 16'hF628

// Control word tags
`define QECIPHY_CTRL_TAG_FAW 8'hA5
`define QECIPHY_CTRL_TAG_CRC 8'h3C

// CRC-16-CCITT, MSB first, no reflection, no final XOR
`define QECIPHY_CRC_POLY 16'h1021
`define QECIPHY_CRC_SEED 16'hFFFF

`endif

//--- logic/qeciphy_frame_pkg.sv
/* Transmit word types
   Data word, CRC value and the 32-bit word with its data and control views */
package qeciphy_frame_pkg;

   // One payload word from the input stream
   typedef logic [31:0] tx_data_t;

   // Running and final CRC-16
   typedef logic [15:0] crc_t;

   // Control view of an output word
   typedef struct packed {
      logic [7:0]  tag;
      logic [7:0]  rsvd;
      // FAW pattern or CRC value
      logic [15:0] value;
   } tx_ctrl_t;

   // Output word, decoded by slot kind
   typedef union packed {
      tx_data_t data;
      tx_ctrl_t ctrl;
   } tx_word_u;

endpackage

//--- logic/qeciphy_slot_pkg.sv
/* Slot kinds of the transmit frame schedule */
package qeciphy_slot_pkg;

   // Kind of the current slot in the 64-slot frame
   typedef enum logic [1:0] {
      SLOT_DATA = 2'd0,
      SLOT_FAW  = 2'd1,
      SLOT_CRC  = 2'd2
   } slot_kind_e;

endpackage

//--- logic/qeciphy_boundary_if.sv
/* Boundary flags and slot advance strobe shared by the framer blocks */
`timescale 1ns/1ns

interface qeciphy_boundary_if
   import qeciphy_slot_pkg::*;
();

   // Flags describe the current slot
   logic       faw_boundary;
   logic       almost_faw_boundary;
   logic       crc_boundary;
   slot_kind_e slot_kind;
   // One cycle high when the current slot is taken into the output register
   logic       slot_adv;

   modport gen (
      output faw_boundary,
      output almost_faw_boundary,
      output crc_boundary,
      output slot_kind,
      input  slot_adv
   );

   modport mux (
      input  faw_boundary,
      input  almost_faw_boundary,
      input  crc_boundary,
      input  slot_kind,
      output slot_adv
   );

   modport mon (
      input faw_boundary,
      input almost_faw_boundary,
      input crc_boundary,
      input slot_kind,
      input slot_adv
   );

endinterface

//--- logic/qeciphy_tx_boundary_gen.sv
/* Slot counter of the transmit frame schedule
   Marks FAW, almost-FAW and CRC boundaries of the current slot */
`timescale 1ns/1ns
`include "qeciphy_tx_consts.svh"

module qeciphy_tx_boundary_gen
   import qeciphy_slot_pkg::*;
(
   input logic             clk_i,
   input logic             rst_n_i,
   qeciphy_boundary_if.gen bnd
);

   localparam logic [5:0] LAST_SLOT = 6'(`QECIPHY_FRAME_SLOTS - 1);
   localparam logic [2:0] CRC_POS   = 3'(`QECIPHY_GROUP_DATA);

   logic [5:0] slot_cnt_q;
   // Position in the current group, 0 to 5 are data, 6 is the CRC word
   logic [2:0] grp_pos_q;
   logic       faw_slot;
   logic       crc_slot;

   assign faw_slot = (slot_cnt_q == 6'd0);
   assign crc_slot = !faw_slot && (grp_pos_q == CRC_POS);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         slot_cnt_q <= '0;
         grp_pos_q  <= '0;
      end else if (bnd.slot_adv) begin
         slot_cnt_q <= (slot_cnt_q == LAST_SLOT) ? 6'd0 : slot_cnt_q + 6'd1;
         // New group starts after the FAW and after every CRC word
         if (faw_slot || crc_slot) begin
            grp_pos_q <= '0;
         end else begin
            grp_pos_q <= grp_pos_q + 3'd1;
         end
      end
   end

   assign bnd.faw_boundary        = faw_slot;
   // Slot 63 is the last CRC word of the frame
   assign bnd.almost_faw_boundary = (slot_cnt_q == LAST_SLOT);
   assign bnd.crc_boundary        = crc_slot;

   always_comb begin
      if (faw_slot) begin
         bnd.slot_kind = SLOT_FAW;
      end else if (crc_slot) begin
         bnd.slot_kind = SLOT_CRC;
      end else begin
         bnd.slot_kind = SLOT_DATA;
      end
   end

endmodule

//--- logic/qeciphy_tx_crc_calc.sv
/* Running CRC-16-CCITT over the data words of the current group
   Reloads the seed when the CRC slot is sent */
`timescale 1ns/1ns
`include "qeciphy_tx_consts.svh"

module qeciphy_tx_crc_calc
   import qeciphy_frame_pkg::*, qeciphy_slot_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  tx_data_t        in_data_i,
   qeciphy_boundary_if.mon bnd,
   output crc_t            crc_o
);

   crc_t crc_q;
   crc_t crc_next;
   logic data_adv;
   logic seed_adv;

   // Fold one word into the CRC, bit 31 first
   function automatic crc_t crc16_word(input crc_t crc_in, input tx_data_t word);
      crc_t crc;
      logic fb;
      crc = crc_in;
      for (int i = 31; i >= 0; i--) begin
         fb  = crc[15] ^ word[i];
         crc = {crc[14:0], 1'b0};
         if (fb) begin
            crc = crc ^ `QECIPHY_CRC_POLY;
         end
      end
      return crc;
   endfunction

   assign data_adv = bnd.slot_adv && (bnd.slot_kind == SLOT_DATA);
   assign seed_adv = bnd.slot_adv && bnd.crc_boundary;
   assign crc_next = crc16_word(crc_q, in_data_i);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         crc_q <= `QECIPHY_CRC_SEED;
      end else if (seed_adv) begin
         crc_q <= `QECIPHY_CRC_SEED;
      end else if (data_adv) begin
         crc_q <= crc_next;
      end
   end

   // Complete value is read by the mux on the CRC slot edge
   assign crc_o = crc_q;

endmodule

//--- logic/qeciphy_tx_word_mux.sv
/* Output word register of the transmit framer
   Picks FAW, CRC or data for each slot and holds under back-pressure */
`timescale 1ns/1ns
`include "qeciphy_tx_consts.svh"

module qeciphy_tx_word_mux
   import qeciphy_frame_pkg::*, qeciphy_slot_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  logic            enable_i,
   input  logic            in_valid_i,
   input  tx_data_t        in_data_i,
   output logic            in_ready_o,
   input  crc_t            crc_i,
   qeciphy_boundary_if.mux bnd,
   output logic            out_valid_o,
   output tx_word_u        out_data_o,
   output slot_kind_e      out_kind_o,
   input  logic            out_ready_i
);

   logic       out_valid_q;
   tx_word_u   out_word_q;
   slot_kind_e out_kind_q;
   tx_word_u   next_word;
   logic       reg_free;
   logic       data_slot;
   logic       fire;

   // Register can take a word when empty or being drained this cycle
   assign reg_free  = !out_valid_q || out_ready_i;
   assign data_slot = (bnd.slot_kind == SLOT_DATA);

   assign in_ready_o   = enable_i && reg_free && data_slot;
   // Control slots need no input word
   assign fire         = enable_i && reg_free && (data_slot ? in_valid_i : 1'b1);
   assign bnd.slot_adv = fire;

   always_comb begin
      next_word = '0;
      if (bnd.faw_boundary) begin
         next_word.ctrl.tag   = `QECIPHY_CTRL_TAG_FAW;
         next_word.ctrl.value = `QECIPHY_FAW_PATTERN;
      end else if (bnd.crc_boundary) begin
         next_word.ctrl.tag   = `QECIPHY_CTRL_TAG_CRC;
         next_word.ctrl.value = crc_i;
      end else begin
         next_word.data = in_data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         out_valid_q <= 1'b0;
      end else if (fire) begin
         out_valid_q <= 1'b1;
      end else if (out_ready_i) begin
         out_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fire) begin
         out_word_q <= next_word;
         out_kind_q <= bnd.slot_kind;
      end
   end

   assign out_valid_o = out_valid_q;
   assign out_data_o  = out_word_q;
   assign out_kind_o  = out_kind_q;

endmodule

//--- logic/qeciphy_tx_boundary_checker.sv
/* Slot-level monitor of the FAW and CRC boundary sequence
   Raises a sticky error on any illegal boundary */
`timescale 1ns/1ns
`include "qeciphy_tx_consts.svh"

module qeciphy_tx_boundary_checker
   import qeciphy_slot_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_n_i,
   qeciphy_boundary_if.mon bnd,
   output logic            error_o
);

   localparam logic [6:0] FRAME_LEN = 7'(`QECIPHY_FRAME_SLOTS);
   localparam logic [2:0] GROUP_LEN = 3'(`QECIPHY_GROUP_DATA);

   logic       seen_faw_q;
   // Slots sent since the last FAW, the FAW itself counts as one
   logic [6:0] frame_cnt_q;
   logic [2:0] data_run_q;
   logic       prev_almost_q;
   logic       error_q;
   logic       crc_bad;
   logic       faw_bad;

   assign crc_bad = bnd.crc_boundary && (!seen_faw_q || (data_run_q != GROUP_LEN));
   // Checks against the previous frame apply from the second FAW on
   assign faw_bad = bnd.faw_boundary && seen_faw_q &&
                    ((frame_cnt_q != FRAME_LEN) || !prev_almost_q);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         seen_faw_q    <= 1'b0;
         frame_cnt_q   <= '0;
         data_run_q    <= '0;
         prev_almost_q <= 1'b0;
         error_q       <= 1'b0;
      end else if (bnd.slot_adv) begin
         prev_almost_q <= bnd.almost_faw_boundary;
         if (bnd.faw_boundary) begin
            seen_faw_q  <= 1'b1;
            frame_cnt_q <= 7'd1;
         end else if (frame_cnt_q != 7'h7f) begin
            frame_cnt_q <= frame_cnt_q + 7'd1;
         end
         // Run of data slots since the last control word, saturating
         if (bnd.slot_kind != SLOT_DATA) begin
            data_run_q <= '0;
         end else if (data_run_q != 3'd7) begin
            data_run_q <= data_run_q + 3'd1;
         end
         if (crc_bad || faw_bad) begin
            error_q <= 1'b1;
         end
      end
   end

   assign error_o = error_q;

endmodule

//--- logic/qeciphy_tx_top.sv
/* Top level of the transmit framing stage
   Boundary generator and CRC calculator feed the output word mux, checked by a monitor */
`timescale 1ns/1ns

module qeciphy_tx_top
   import qeciphy_frame_pkg::*, qeciphy_slot_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  logic        enable_i,
   // Input word stream
   input  logic        in_valid_i,
   input  tx_data_t    in_data_i,
   output logic        in_ready_o,
   // Framed output stream
   output logic        out_valid_o,
   output logic [31:0] out_data_o,
   output slot_kind_e  out_kind_o,
   input  logic        out_ready_i,
   // Sticky boundary error
   output logic        error_o
);

   crc_t     crc;
   tx_word_u out_word;

   qeciphy_boundary_if bnd ();

   qeciphy_tx_boundary_gen u_boundary_gen (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bnd     (bnd.gen)
   );

   qeciphy_tx_crc_calc u_crc_calc (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .in_data_i (in_data_i),
      .bnd       (bnd.mon),
      .crc_o     (crc)
   );

   qeciphy_tx_word_mux u_word_mux (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .enable_i    (enable_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .in_ready_o  (in_ready_o),
      .crc_i       (crc),
      .bnd         (bnd.mux),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_word),
      .out_kind_o  (out_kind_o),
      .out_ready_i (out_ready_i)
   );

   qeciphy_tx_boundary_checker u_boundary_checker (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bnd     (bnd.mon),
      .error_o (error_o)
   );

   // Union leaves the top as a flat 32-bit word
   assign out_data_o = out_word;

endmodule

//--- bench/qeciphy_tx_monitor.sv
/* Output stream monitor of the transmit framer
   Rebuilds the expected frames from the input word queue and compares */
`timescale 1ns/1ns
`include "qeciphy_tx_consts.svh"

module qeciphy_tx_monitor
   import qeciphy_slot_pkg::*;
(
   input logic        clk_i,
   input logic        rst_n_i,
   input logic        enable_i,
   input logic        in_ready_i,
   input logic        out_valid_i,
   input logic [31:0] out_data_i,
   input slot_kind_e  out_kind_i,
   input logic        out_ready_i,
   input logic        error_i
);

   // Accepted input words, oldest first
   logic [31:0] data_q[$];
   string       test_name = "reset";
   int          err_count = 0;
   int          word_count = 0;
   // Frame slot of the next word expected on the output
   int unsigned slot = 0;
   logic [15:0] crc_model = `QECIPHY_CRC_SEED;
   logic        held = 1'b0;
   logic [31:0] held_data = '0;
   logic        prev_enable = 1'b0;
   logic        prev_free = 1'b0;
   logic        error_seen = 1'b0;

   // Slot 0 is the FAW, the last slot of every seven after it is a CRC word
   function automatic slot_kind_e kind_of(input int unsigned s);
      if (s == 0) begin
         return SLOT_FAW;
      end else if ((s - 1) % (`QECIPHY_GROUP_DATA + 1) == `QECIPHY_GROUP_DATA) begin
         return SLOT_CRC;
      end
      return SLOT_DATA;
   endfunction

   // CRC-16-CCITT one byte at a time, most significant byte first
   function automatic logic [15:0] crc_fold(input logic [15:0] crc_in, input logic [31:0] word);
      logic [15:0] c;
      c = crc_in;
      for (int k = 3; k >= 0; k--) begin
         c = c ^ {word[8*k +: 8], 8'h00};
         for (int n = 0; n < 8; n++) begin
            c = c[15] ? ({c[14:0], 1'b0} ^ `QECIPHY_CRC_POLY) : {c[14:0], 1'b0};
         end
      end
      return c;
   endfunction

   task automatic check_word();
      slot_kind_e  exp_kind;
      logic [31:0] exp_word;
      exp_kind = kind_of(slot);
      exp_word = '0;
      if (out_kind_i != exp_kind) begin
         $display("Fail %s: slot %0d kind expected %s, actual %s",
                  test_name, slot, exp_kind.name(), out_kind_i.name());
         err_count++;
      end
      case (exp_kind)
         SLOT_FAW: exp_word = {`QECIPHY_CTRL_TAG_FAW, 8'h00, `QECIPHY_FAW_PATTERN};
         SLOT_CRC: exp_word = {`QECIPHY_CTRL_TAG_CRC, 8'h00, crc_model};
         default: begin
            if (data_q.size() == 0) begin
               $display("Error in %s: data word sent with no input word pending", test_name);
               err_count++;
            end else begin
               exp_word = data_q.pop_front();
            end
         end
      endcase
      crc_model = (exp_kind == SLOT_DATA) ? crc_fold(crc_model, exp_word) : `QECIPHY_CRC_SEED;
      if (out_data_i !== exp_word) begin
         $display("Fail %s: slot %0d word expected %h, actual %h",
                  test_name, slot, exp_word, out_data_i);
         err_count++;
      end
      word_count++;
      slot = (slot + 1) % `QECIPHY_FRAME_SLOTS;
   endtask

   always @(posedge clk_i) begin
      if (rst_n_i) begin
         if (error_i && !error_seen) begin
            $display("Error in %s: boundary error flag raised", test_name);
            err_count++;
            error_seen = 1'b1;
         end
         if (held && (!out_valid_i || out_data_i !== held_data)) begin
            $display("Fail %s: held word expected %h, actual %h", test_name, held_data, out_data_i);
            err_count++;
         end
         if (!prev_enable && prev_free && out_valid_i) begin
            $display("Error in %s: output word produced while enable was low", test_name);
            err_count++;
         end
         // The register holds the word of the current slot when valid
         if (in_ready_i &&
             (!enable_i || kind_of(out_valid_i ? (slot + 1) % 64 : slot) != SLOT_DATA)) begin
            $display("Error in %s: input ready outside an enabled data slot", test_name);
            err_count++;
         end
         if (out_valid_i && out_ready_i) begin
            check_word();
         end
         held        = out_valid_i && !out_ready_i;
         held_data   = out_data_i;
         prev_enable = enable_i;
         prev_free   = !out_valid_i || out_ready_i;
      end
   end

endmodule

//--- bench/qeciphy_tx_tb.sv
/* Testbench of the transmit framer
   Clock, reset, stimulus table applied in a loop, DUT and monitor instances */
`timescale 1ns/1ns

module qeciphy_tx_tb
   import qeciphy_slot_pkg::*;
();

   localparam int READY_ALWAYS = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_BURST  = 2;
   localparam int EN_ALWAYS    = 0;
   localparam int EN_GAPS      = 1;

   typedef struct {
      string name;
      int    n_words;
      int    ready_mode;
      int    en_mode;
   } test_t;

   logic        clk_i;
   logic        rst_n_i;
   logic        enable_i;
   logic        in_valid_i;
   logic [31:0] in_data_i;
   logic        in_ready_o;
   logic        out_valid_o;
   logic [31:0] out_data_o;
   slot_kind_e  out_kind_o;
   logic        out_ready_i;
   logic        error_o;
   test_t       tests[5];
   int          cyc = 0;
   int          timeouts = 0;

   function automatic logic ready_for(input int mode);
      case (mode)
         READY_RANDOM: return ($urandom % 4) != 0;
         // Five stalled cycles out of every sixteen
         READY_BURST:  return (cyc % 16) < 11;
         default:      return 1'b1;
      endcase
   endfunction

   function automatic logic enable_for(input int mode);
      return (mode == EN_GAPS) ? ((cyc % 23) >= 4) : 1'b1;
   endfunction

   task automatic run_test(input test_t t);
      int sent;
      int waited;
      sent   = 0;
      waited = 0;
      u_monitor.test_name = t.name;
      while (sent < t.n_words && waited < t.n_words * 30 + 200) begin
         @(posedge clk_i);
         waited++;
         cyc++;
         if (in_valid_i && in_ready_o) begin
            u_monitor.data_q.push_back(in_data_i);
            sent++;
         end
         if (sent < t.n_words && (!in_valid_i || in_ready_o)) begin
            in_data_i  <= $urandom;
            in_valid_i <= 1'b1;
         end else if (sent >= t.n_words) begin
            in_valid_i <= 1'b0;
         end
         out_ready_i <= ready_for(t.ready_mode);
         enable_i    <= enable_for(t.en_mode);
      end
      if (sent < t.n_words) begin
         $display("Error in %s: timeout waiting for input words, %0d sent", t.name, sent);
         timeouts++;
      end
      waited = 0;
      while (u_monitor.data_q.size() != 0 && waited < 2000) begin
         @(posedge clk_i);
         waited++;
         cyc++;
         out_ready_i <= ready_for(t.ready_mode);
         enable_i    <= 1'b1;
      end
      if (u_monitor.data_q.size() != 0) begin
         $display("Error in %s: timeout waiting for data words on the output", t.name);
         timeouts++;
      end
      // Stop the schedule and let the register drain
      enable_i    <= 1'b0;
      out_ready_i <= 1'b1;
      waited = 0;
      do begin
         @(posedge clk_i);
         waited++;
      end while (out_valid_o && waited < 100);
      if (out_valid_o) begin
         $display("Error in %s: timeout waiting for the output register to drain", t.name);
         timeouts++;
      end
   endtask

   qeciphy_tx_top DUT (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .enable_i    (enable_i),
      .in_valid_i  (in_valid_i),
      .in_data_i   (in_data_i),
      .in_ready_o  (in_ready_o),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_kind_o  (out_kind_o),
      .out_ready_i (out_ready_i),
      .error_o     (error_o)
   );

   qeciphy_tx_monitor u_monitor (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .enable_i    (enable_i),
      .in_ready_i  (in_ready_o),
      .out_valid_i (out_valid_o),
      .out_data_i  (out_data_o),
      .out_kind_i  (out_kind_o),
      .out_ready_i (out_ready_i),
      .error_i     (error_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   initial begin
      rst_n_i     = 1'b0;
      enable_i    = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      void'($urandom(38));
      tests[0] = '{"full_frames", 130, READY_ALWAYS, EN_ALWAYS};
      tests[1] = '{"random_ready", 110, READY_RANDOM, EN_ALWAYS};
      tests[2] = '{"stall_bursts", 110, READY_BURST, EN_ALWAYS};
      tests[3] = '{"enable_gaps", 90, READY_ALWAYS, EN_GAPS};
      tests[4] = '{"mixed_stress", 200, READY_RANDOM, EN_GAPS};
      repeat (8) @(posedge clk_i);
      rst_n_i <= 1'b1;
      foreach (tests[i]) begin
         run_test(tests[i]);
      end
      $display("Checked %0d words, %0d value errors, %0d timeouts",
               u_monitor.word_count, u_monitor.err_count, timeouts);
      if (u_monitor.err_count == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+logic
logic/qeciphy_frame_pkg.sv
logic/qeciphy_slot_pkg.sv
logic/qeciphy_boundary_if.sv
logic/qeciphy_tx_boundary_gen.sv
logic/qeciphy_tx_crc_calc.sv
logic/qeciphy_tx_word_mux.sv
logic/qeciphy_tx_boundary_checker.sv
logic/qeciphy_tx_top.sv
bench/qeciphy_tx_monitor.sv
bench/qeciphy_tx_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := qeciphy_tx_tb
RTL_TOP    := qeciphy_tx_top
FLIST      := flist.f
RTL_SRCS   := logic/qeciphy_frame_pkg.sv logic/qeciphy_slot_pkg.sv \
              logic/qeciphy_boundary_if.sv logic/qeciphy_tx_boundary_gen.sv \
              logic/qeciphy_tx_crc_calc.sv logic/qeciphy_tx_word_mux.sv \
              logic/qeciphy_tx_boundary_checker.sv logic/qeciphy_tx_top.sv
LINT_FLAGS := --lint-only -Wall +incdir+logic
SIM_FLAGS  := --binary --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR) -o sim_$(TOP)
	./$(OBJ_DIR)/sim_$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
